// File: logic/link_pkg.sv
// shared constants and types for the single clock master link kernel; changing depth also changes start credits
package link_pkg;

  // --------------------------------------------------
  // link geometry
  // --------------------------------------------------

  // number of source synchronous channels
  localparam int link_channels_lp = 2;

  // bits per line and core word
  localparam int channel_width_lp = 8;

  // receive fifo holds 2**lg words
  localparam int lg_fifo_depth_lp = 3;
  localparam int fifo_depth_lp = 1 << lg_fifo_depth_lp;

  // sender starts with one credit per far side fifo slot
  localparam int start_credits_lp = fifo_depth_lp;

  // one token stands for 2**lg dequeues
  localparam int lg_token_decimation_lp = 1;
  localparam int token_credits_lp = 1 << lg_token_decimation_lp;

  // --------------------------------------------------
  // calibration timing
  // --------------------------------------------------

  // idle cycles between reset release and prepare
  localparam int wait_after_reset_lp = 16;

  // cycles that slave reset and channel resets are held
  localparam int prepare_cycles_lp = 32;

  // the longer of the two phases sets the counter width
  localparam int calib_cnt_width_lp = $clog2(prepare_cycles_lp);

  // --------------------------------------------------
  // types
  // --------------------------------------------------

  typedef logic [channel_width_lp-1:0] data_t;

  // one bit per channel
  typedef logic [link_channels_lp-1:0] chan_vec_t;

  // holds 0 to fifo_depth_lp inclusive
  typedef logic [lg_fifo_depth_lp:0] credit_t;

  typedef enum logic [1:0] {
    calib_wait,
    calib_prepare,
    calib_done
  } calib_state_e;

endpackage

// File: logic/link_calib_ctrl.sv
// fixed length sequence only; no per channel tests or timeout and no restart short of a reset
`timescale 1ns/1ns

module link_calib_ctrl
  import link_pkg::*;
  (input  logic io_master_clk_i
  ,input  logic rst_n_i
  ,output logic slave_reset_o
  ,output logic link_up_o
  );

  // --------------------------------------------------
  // sequencer state
  // --------------------------------------------------

  calib_state_e                  state_r;
  logic [calib_cnt_width_lp-1:0] cnt_r;

  // last count value of each timed phase
  localparam logic [calib_cnt_width_lp-1:0] wait_last_lp =
    calib_cnt_width_lp'(wait_after_reset_lp - 1);
  localparam logic [calib_cnt_width_lp-1:0] prepare_last_lp =
    calib_cnt_width_lp'(prepare_cycles_lp - 1);

  // wait -> prepare -> done and then stay in done
  always_ff @(posedge io_master_clk_i) begin
    if (!rst_n_i) begin
      state_r <= calib_wait;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        calib_wait: begin
          // counter restarts so prepare is timed from zero
          if (cnt_r == wait_last_lp) begin
            state_r <= calib_prepare;
            cnt_r   <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        calib_prepare: begin
          if (cnt_r == prepare_last_lp) begin
            state_r <= calib_done;
            cnt_r   <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        // done is terminal and the counter parks
        default: begin
          state_r <= calib_done;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // registered outputs
  // --------------------------------------------------

  // one cycle behind the state so the line sees clean edges
  always_ff @(posedge io_master_clk_i) begin
    if (!rst_n_i) begin
      slave_reset_o <= 1'b0;
      link_up_o     <= 1'b0;
    end else begin
      slave_reset_o <= (state_r == calib_prepare);
      link_up_o     <= (state_r == calib_done);
    end
  end

endmodule

// File: logic/link_credit_out.sv
// sender must not get more tokens back than words it sent; credits are not saturated
`timescale 1ns/1ns

module link_credit_out
  import link_pkg::*;
  (input  logic  io_master_clk_i
  ,input  logic  rst_n_i
  ,input  logic  link_up_i

  // core side valid/ready
  ,input  logic  valid_i
  ,input  data_t data_i
  ,output logic  ready_o

  // one pulse per returned token
  ,input  logic  token_i

  // line side
  ,output logic  tline_valid_o
  ,output data_t tline_data_o
  );

  // --------------------------------------------------
  // credit counter
  // --------------------------------------------------

  credit_t credits_r;
  credit_t token_add;
  logic    accept;

  // a word may go out only with a free far side slot
  assign ready_o = link_up_i & (credits_r != '0);
  assign accept  = valid_i & ready_o;

  // each token is worth a whole decimation group
  assign token_add = token_i ? credit_t'(token_credits_lp) : '0;

  // reload while the link is down since the far fifo is being emptied
  always_ff @(posedge io_master_clk_i) begin
    if (!rst_n_i || !link_up_i) begin
      credits_r <= credit_t'(start_credits_lp);
    end else begin
      // token and accept may land on the same edge
      credits_r <= credits_r + token_add - credit_t'(accept);
    end
  end

  // --------------------------------------------------
  // line launch registers
  // --------------------------------------------------

  // valid follows acceptance one cycle later
  always_ff @(posedge io_master_clk_i) begin
    if (!rst_n_i) begin
      tline_valid_o <= 1'b0;
    end else begin
      tline_valid_o <= accept;
    end
  end

  // data only moves on an accepted word
  // stale data stays on idle cycles
  always_ff @(posedge io_master_clk_i) begin
    if (accept) begin
      tline_data_o <= data_i;
    end
  end

endmodule

// File: logic/link_token_in.sv
// words that arrive into a full fifo are dropped; the far side credit count must prevent that
`timescale 1ns/1ns

module link_token_in
  import link_pkg::*;
  (input  logic  io_master_clk_i
  ,input  logic  rst_n_i
  ,input  logic  link_up_i

  // line side
  ,input  logic  tline_valid_i
  ,input  data_t tline_data_i

  // core side valid/yumi
  ,output logic  valid_o
  ,output data_t data_o
  ,input  logic  yumi_i

  // token back to the sender
  ,output logic  token_o
  );

  // --------------------------------------------------
  // receive fifo
  // --------------------------------------------------

  data_t                       mem_r [fifo_depth_lp];
  logic [lg_fifo_depth_lp-1:0] wr_ptr_r;
  logic [lg_fifo_depth_lp-1:0] rd_ptr_r;
  credit_t                     count_r;
  logic                        full;
  logic                        enq;
  logic                        deq;

  assign full    = (count_r == credit_t'(fifo_depth_lp));
  assign valid_o = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  // no writes until calibration is over
  assign enq = tline_valid_i & link_up_i & ~full;
  // yumi is only legal with valid but guard anyway
  assign deq = yumi_i & valid_o;

  // storage has no reset
  always_ff @(posedge io_master_clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= tline_data_i;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge io_master_clk_i) begin
    if (!rst_n_i || !link_up_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      // simultaneous enq and deq leaves the count alone
      count_r <= count_r + credit_t'(enq) - credit_t'(deq);
    end
  end

  // --------------------------------------------------
  // token decimation
  // --------------------------------------------------

  logic [lg_token_decimation_lp-1:0] deq_cnt_r;
  logic                              wrap;

  // last dequeue of a group
  assign wrap = deq & (&deq_cnt_r);

  always_ff @(posedge io_master_clk_i) begin
    if (!rst_n_i || !link_up_i) begin
      deq_cnt_r <= '0;
      token_o   <= 1'b0;
    end else begin
      if (deq) begin
        deq_cnt_r <= deq_cnt_r + 1'b1;
      end
      // single cycle pulse the cycle after the wrap
      token_o <= wrap;
    end
  end

endmodule

// File: logic/link_channel.sv
// one channel; in loopback the core side is cut off in both directions
`timescale 1ns/1ns

module link_channel
  import link_pkg::*;
  (input  logic  io_master_clk_i
  ,input  logic  rst_n_i
  ,input  logic  link_up_i
  ,input  logic  loopback_en_i

  // core in
  ,input  logic  core_valid_i
  ,input  data_t core_data_i
  ,output logic  core_ready_o

  // core out
  ,output logic  core_valid_o
  ,output data_t core_data_o
  ,input  logic  core_yumi_i

  // line
  ,input  logic  tline_valid_i
  ,input  data_t tline_data_i
  ,output logic  tline_valid_o
  ,output data_t tline_data_o
  ,input  logic  token_i
  ,output logic  token_o
  );

  logic  out_valid;
  data_t out_data;
  logic  out_ready;
  logic  in_valid;
  data_t in_data;
  logic  in_yumi;

  // --------------------------------------------------
  // loopback selection
  // --------------------------------------------------

  // fifo head feeds the sender directly in loopback
  assign out_valid = loopback_en_i ? in_valid : core_valid_i;
  assign out_data  = loopback_en_i ? in_data : core_data_i;
  assign in_yumi   = loopback_en_i ? (out_ready & in_valid) : core_yumi_i;

  // core handshakes stay quiet in loopback
  assign core_ready_o = out_ready & ~loopback_en_i;
  assign core_valid_o = in_valid & ~loopback_en_i;
  assign core_data_o  = in_data;

  link_credit_out credit_out_inst
    (.io_master_clk_i(io_master_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.link_up_i      (link_up_i)
    ,.valid_i        (out_valid)
    ,.data_i         (out_data)
    ,.ready_o        (out_ready)
    ,.token_i        (token_i)
    ,.tline_valid_o  (tline_valid_o)
    ,.tline_data_o   (tline_data_o)
    );

  link_token_in token_in_inst
    (.io_master_clk_i(io_master_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.link_up_i      (link_up_i)
    ,.tline_valid_i  (tline_valid_i)
    ,.tline_data_i   (tline_data_i)
    ,.valid_o        (in_valid)
    ,.data_o         (in_data)
    ,.yumi_i         (in_yumi)
    ,.token_o        (token_o)
    );

endmodule

// File: logic/link_kernel.sv
// master side only with everything on io_master_clk_i; channels stay in reset until calib_done_o
`timescale 1ns/1ns

module link_kernel
  import link_pkg::*;
  (input  logic      io_master_clk_i
  ,input  logic      rst_n_i
  ,input  chan_vec_t loopback_en_i

  // status
  ,output logic      calib_done_o
  ,output logic      im_slave_reset_tline_o

  // core in
  ,input  chan_vec_t core_valid_i
  ,input  data_t     core_data_i [link_channels_lp-1:0]
  ,output chan_vec_t core_ready_o

  // core out
  ,output chan_vec_t core_valid_o
  ,output data_t     core_data_o [link_channels_lp-1:0]
  ,input  chan_vec_t core_yumi_i

  // line in and token out
  ,input  chan_vec_t io_valid_tline_i
  ,input  data_t     io_data_tline_i [link_channels_lp-1:0]
  ,output chan_vec_t io_token_tline_o

  // line out and token in
  ,output chan_vec_t im_valid_tline_o
  ,output data_t     im_data_tline_o [link_channels_lp-1:0]
  ,input  chan_vec_t token_tline_i
  );

  // --------------------------------------------------
  // calibration
  // --------------------------------------------------

  // also the channel enable
  logic link_up;

  link_calib_ctrl calib_ctrl_inst
    (.io_master_clk_i(io_master_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.slave_reset_o  (im_slave_reset_tline_o)
    ,.link_up_o      (link_up)
    );

  assign calib_done_o = link_up;

  // --------------------------------------------------
  // channels
  // --------------------------------------------------

  for (genvar i = 0; i < link_channels_lp; i++) begin : ch
    link_channel link_channel_inst
      (.io_master_clk_i(io_master_clk_i)
      ,.rst_n_i        (rst_n_i)
      ,.link_up_i      (link_up)
      ,.loopback_en_i  (loopback_en_i[i])
      ,.core_valid_i   (core_valid_i[i])
      ,.core_data_i    (core_data_i[i])
      ,.core_ready_o   (core_ready_o[i])
      ,.core_valid_o   (core_valid_o[i])
      ,.core_data_o    (core_data_o[i])
      ,.core_yumi_i    (core_yumi_i[i])
      ,.tline_valid_i  (io_valid_tline_i[i])
      ,.tline_data_i   (io_data_tline_i[i])
      ,.tline_valid_o  (im_valid_tline_o[i])
      ,.tline_data_o   (im_data_tline_o[i])
      ,.token_i        (token_tline_i[i])
      ,.token_o        (io_token_tline_o[i])
      );
  end

endmodule

// File: bench/link_kernel_tb.sv
// expects even word counts and at most 8 words per step in modes 3 and 4; vectors path is relative to the root
`timescale 1ns/1ns

module link_kernel_tb
  import link_pkg::*;
  ;

  logic      io_master_clk_i;
  logic      rst_n_i;
  chan_vec_t loopback_en;
  logic      calib_done;
  logic      slave_reset;
  chan_vec_t core_valid_in;
  data_t     core_data_in [link_channels_lp-1:0];
  chan_vec_t core_ready;
  chan_vec_t core_valid_out;
  data_t     core_data_out [link_channels_lp-1:0];
  chan_vec_t core_yumi;
  chan_vec_t io_valid;
  data_t     io_data [link_channels_lp-1:0];
  chan_vec_t io_token;
  chan_vec_t im_valid;
  data_t     im_data [link_channels_lp-1:0];
  chan_vec_t token_in;

  // one packed word per step holding mode channel seed and count
  logic [31:0] vecs [0:31];
  int          step;
  int          limit_cycles;
  logic        far_en;

  link_kernel link_kernel_inst
    (.io_master_clk_i       (io_master_clk_i)
    ,.rst_n_i               (rst_n_i)
    ,.loopback_en_i         (loopback_en)
    ,.calib_done_o          (calib_done)
    ,.im_slave_reset_tline_o(slave_reset)
    ,.core_valid_i          (core_valid_in)
    ,.core_data_i           (core_data_in)
    ,.core_ready_o          (core_ready)
    ,.core_valid_o          (core_valid_out)
    ,.core_data_o           (core_data_out)
    ,.core_yumi_i           (core_yumi)
    ,.io_valid_tline_i      (io_valid)
    ,.io_data_tline_i       (io_data)
    ,.io_token_tline_o      (io_token)
    ,.im_valid_tline_o      (im_valid)
    ,.im_data_tline_o       (im_data)
    ,.token_tline_i         (token_in)
    );

  // --------------------------------------------------
  // clock, far side and watchdog
  // --------------------------------------------------

  initial begin
    io_master_clk_i = 1'b0;
    forever #50 io_master_clk_i = ~io_master_clk_i;
  end

  // far side returns line words one cycle later and passes tokens back
  always begin
    chan_vec_t lv;
    chan_vec_t tk;
    data_t     ld [link_channels_lp-1:0];
    @(posedge io_master_clk_i);
    #5;
    lv = im_valid;
    tk = io_token;
    ld = im_data;
    #5;
    if (far_en) begin
      io_valid = lv;
      io_data  = ld;
      token_in = tk;
    end
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge io_master_clk_i);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Test failed");
    $fatal(1);
  end

  // --------------------------------------------------
  // check helpers
  // --------------------------------------------------

  task automatic compare_value(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("Fail %s step %0d: expected %0h actual %0h", what, step, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic require_true(input logic ok, input string msg);
    assert (ok) else begin
      $display("step %0d: %s", step, msg);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // sample point of a cycle; inputs change 5 ns later
  task automatic wait_sample_point();
    @(posedge io_master_clk_i);
    #5;
  endtask

  // --------------------------------------------------
  // step runners
  // --------------------------------------------------

  // core -> line -> far side -> line -> core under random yumi stalls
  task automatic far_side_round_trip(input int ch, input data_t seed, input int cnt);
    int   sent;
    int   rcvd;
    logic rdy;
    logic y;
    sent   = 0;
    rcvd   = 0;
    far_en = 1'b1;
    while (rcvd < cnt) begin
      wait_sample_point();
      rdy = core_ready[ch];
      require_true(core_valid_out[1-ch] == 1'b0, "word appeared on the idle channel");
      y = 1'b0;
      if (core_valid_out[ch]) begin
        y = ($urandom % 4) != 0;
        if (y) begin
          compare_value("far loop data", data_t'(seed + rcvd), core_data_out[ch]);
          rcvd++;
        end
      end
      #5;
      core_yumi[ch]     = y;
      core_valid_in[ch] = sent < cnt;
      core_data_in[ch]  = data_t'(seed + sent);
      if (sent < cnt && rdy) sent++;
    end
    wait_sample_point();
    #5;
    core_valid_in[ch] = 1'b0;
    core_yumi[ch]     = 1'b0;
    // let the last token land before the far side goes away
    repeat (4) wait_sample_point();
    far_en = 1'b0;
    #5;
    io_valid = '0;
    token_in = '0;
  endtask

  // credits stop at 8 and each token pulse buys exactly 2 words
  task automatic exhaust_credits(input int ch, input data_t seed, input int cnt);
    int   acc;
    int   seen;
    int   allowed;
    int   stall;
    logic rdy;
    acc     = 0;
    seen    = 0;
    allowed = start_credits_lp;
    stall   = 0;
    while (seen < cnt) begin
      wait_sample_point();
      rdy = core_ready[ch];
      compare_value("ready vs credits", int'(acc < allowed), rdy);
      compare_value("core valid in credit step", 0, core_valid_out[ch]);
      if (im_valid[ch]) begin
        compare_value("line data", data_t'(seed + seen), im_data[ch]);
        seen++;
      end
      stall = rdy ? 0 : stall + 1;
      #5;
      token_in[ch]      = 1'b0;
      core_valid_in[ch] = acc < cnt;
      core_data_in[ch]  = data_t'(seed + acc);
      if (acc < cnt && rdy) acc++;
      if (stall >= 4 && acc < cnt) begin
        token_in[ch] = 1'b1;
        allowed += token_credits_lp;
        stall = 0;
      end
    end
    compare_value("accepted words", cnt, acc);
    // hand back the whole window for the next steps
    core_valid_in[ch] = 1'b0;
    repeat (start_credits_lp / token_credits_lp) begin
      wait_sample_point();
      #5;
      token_in[ch] = 1'b1;
    end
    wait_sample_point();
    #5;
    token_in[ch] = 1'b0;
    wait_sample_point();
    require_true(core_ready[ch], "ready stayed low after the credits came back");
  endtask

  // line words dequeued by the core with one token per two dequeues
  task automatic count_token_pulses(input int ch, input data_t seed, input int cnt);
    int sent;
    int rcvd;
    int toks;
    sent = 0;
    rcvd = 0;
    toks = 0;
    while (rcvd < cnt) begin
      wait_sample_point();
      if (io_token[ch]) toks++;
      require_true(core_valid_out[1-ch] == 1'b0, "word appeared on the idle channel");
      if (core_valid_out[ch]) begin
        compare_value("dequeued data", data_t'(seed + rcvd), core_data_out[ch]);
        rcvd++;
      end
      #5;
      core_yumi[ch] = core_valid_out[ch];
      io_valid[ch]  = sent < cnt;
      io_data[ch]   = data_t'(seed + sent);
      if (sent < cnt) sent++;
    end
    repeat (3) begin
      wait_sample_point();
      if (io_token[ch]) toks++;
      #5;
      core_yumi[ch] = 1'b0;
      io_valid[ch]  = 1'b0;
    end
    compare_value("token pulses", cnt / token_credits_lp, toks);
  endtask

  // line in -> fifo -> line out without the core
  task automatic line_loopback(input int ch, input data_t seed, input int cnt);
    int   sent;
    int   seen;
    logic give;
    sent = 0;
    seen = 0;
    give = 1'b0;
    while (seen < cnt) begin
      wait_sample_point();
      compare_value("core valid in loopback", 0, core_valid_out[ch]);
      give = 1'b0;
      if (im_valid[ch]) begin
        compare_value("loopback data", data_t'(seed + seen), im_data[ch]);
        seen++;
        give = (seen % token_credits_lp) == 0;
      end
      #5;
      loopback_en[ch] = 1'b1;
      token_in[ch]    = give;
      io_valid[ch]    = sent < cnt;
      io_data[ch]     = data_t'(seed + sent);
      if (sent < cnt) sent++;
    end
    wait_sample_point();
    #5;
    token_in[ch] = 1'b0;
    io_valid[ch] = 1'b0;
    repeat (2) wait_sample_point();
    #5;
    loopback_en[ch] = 1'b0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int total;
    int cyc;
    void'($urandom(32'h23f5));
    rst_n_i         = 1'b0;
    loopback_en     = '0;
    core_valid_in   = '0;
    core_yumi       = '0;
    io_valid        = '0;
    token_in        = '0;
    far_en          = 1'b0;
    step            = 0;
    limit_cycles    = 0;
    for (int i = 0; i < link_channels_lp; i++) begin
      core_data_in[i] = '0;
      io_data[i]      = '0;
    end
    for (int i = 0; i < 32; i++) vecs[i] = '0;
    $readmemh("bench/link_kernel_vectors.txt", vecs);
    total = 0;
    for (int i = 0; i < 32; i++) total += vecs[i][7:0];
    limit_cycles = 200 * total + 100;

    repeat (2) @(posedge io_master_clk_i);
    #10;
    rst_n_i = 1'b1;

    // cycle 1 is the first edge with reset high
    for (cyc = 1; cyc <= 50; cyc++) begin
      wait_sample_point();
      compare_value("slave reset", int'(cyc >= 17 && cyc <= 48), slave_reset);
      compare_value("calib done", int'(cyc >= 49), calib_done);
      if (cyc < 49) begin
        compare_value("core ready before done", 0, core_ready);
        compare_value("core valid before done", 0, core_valid_out);
        compare_value("line valid before done", 0, im_valid);
        compare_value("token before done", 0, io_token);
      end
    end

    for (step = 0; step < 32 && vecs[step][7:0] != 0; step++) begin
      case (vecs[step][31:24])
        8'h01: far_side_round_trip(vecs[step][16], vecs[step][15:8], vecs[step][7:0]);
        8'h02: exhaust_credits(vecs[step][16], vecs[step][15:8], vecs[step][7:0]);
        8'h03: count_token_pulses(vecs[step][16], vecs[step][15:8], vecs[step][7:0]);
        8'h04: line_loopback(vecs[step][16], vecs[step][15:8], vecs[step][7:0]);
        default: require_true(1'b0, "unknown mode in the vector file");
      endcase
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: bench/link_kernel_vectors.txt
// one step per line in hex: mode_channel_seed_count
// mode 01 far side loop, 02 credit limit, 03 token generation, 04 loopback
01_00_10_10
01_01_40_0c
02_00_80_0c
02_01_c0_0e
03_00_20_08
03_01_f8_06
04_00_55_08
04_01_aa_06
01_00_f0_08
01_01_33_0a

// File: files.f
logic/link_pkg.sv
logic/link_calib_ctrl.sv
logic/link_credit_out.sv
logic/link_token_in.sv
logic/link_channel.sv
logic/link_kernel.sv
bench/link_kernel_tb.sv

// File: Makefile
# Verilator build and run for the link kernel testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f files.f --top-module link_kernel_tb -o Vlink_kernel_tb

run: build
	./obj_dir/Vlink_kernel_tb 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module link_kernel_tb

clean:
	rm -rf obj_dir $(LOG)
